//--- test/bus_ctrl_testdata.txt
# op name byte_addr value expected, all hex; W write, R read, C counter rises, P pins of port
# P value = {phy[15:0], mod_abs, tx_fault, rx_los}, O expected = {leds, sw_rst, clk_ctrl, rs}
O reset_values 000 00000000 00004000
W led_write 000 000000a5 00000000
W swrst_write 004 0000000b 00000000
W clkctl_write 008 00000013 00000000
W rs0_write 020 00000002 00000000
W rs1_write 024 00000001 00000000
W unmapped_write 3fc ffffffff 00000000
O settings_out 000 00000000 a50b1306
R compat 018 00000000 000f0000
R clk_status 00c 00000000 0000005a
R eth_type0 010 00000000 00000001
R eth_type1 014 00000000 00000000
R unmapped_read 3f0 00000000 00000000
P pins_p0 000 000091a5 00000000
P pins_p1 001 0005f77b 00000000
R status_p0 020 00000000 1234002d
R status_p0_clr 020 00000000 12340005
R status_p1 024 00000000 beef001b
R status_p1_clr 024 00000000 beef0003
C counter_rise 000 00000000 00000000

//--- compile.f
+incdir+logic
logic/bus_ctrl_pkg.sv
logic/axil_settings_slave.sv
logic/ctrl_setting_regs.sv
logic/sfp_port_monitor.sv
logic/readback_mux.sv
logic/bus_ctrl_top.sv
test/bus_ctrl_asserts.sv
test/bus_ctrl_tb.sv

//--- test/bus_ctrl_tb.sv
// ----------------------------------------------------------
// Self-checking testbench for the board control block
// Runs the operations listed in test/bus_ctrl_testdata.txt
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module bus_ctrl_tb;
   import bus_ctrl_pkg::*;

   localparam int RST_CYCLES      = 16;
   localparam int CYCLES_PER_LINE = 60;

   logic                                             clk;
   logic                                             arst_n;
   logic [`BUS_CTRL_AXI_AW-1:0]                      awaddr;
   logic                                             awvalid;
   logic                                             awready;
   reg_data_t                                        wdata;
   logic                                             wvalid;
   logic                                             wready;
   logic [1:0]                                       bresp;
   logic                                             bvalid;
   logic                                             bready;
   logic [`BUS_CTRL_AXI_AW-1:0]                      araddr;
   logic                                             arvalid;
   logic                                             arready;
   reg_data_t                                        rdata;
   logic [1:0]                                       rresp;
   logic                                             rvalid;
   logic                                             rready;
   logic [7:0]                                       clock_status;
   logic [`BUS_CTRL_NUM_SFP-1:0]                     mod_abs;
   logic [`BUS_CTRL_NUM_SFP-1:0]                     tx_fault;
   logic [`BUS_CTRL_NUM_SFP-1:0]                     rx_los;
   logic [`BUS_CTRL_NUM_SFP-1:0][`BUS_CTRL_PHY_W-1:0] phy_status;
   logic [7:0]                                       leds;
   logic [3:0]                                       sw_rst;
   logic [7:0]                                       clock_control;
   logic [`BUS_CTRL_NUM_SFP-1:0][1:0]                rs_drive_low;

   int          n_checks;
   int          n_errors;
   int          cycle_count;
   int          cycle_limit;
   logic [31:0] lfsr_state;
   // Parsed data file, one entry per operation
   string       op_q[$];
   string       name_q[$];
   logic [31:0] addr_q[$];
   logic [31:0] value_q[$];
   logic [31:0] exp_q[$];

   bus_ctrl_top i_bus_ctrl_top (
      .clk(clk), .i_arst_n(arst_n),
      .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
      .i_wdata(wdata), .i_wvalid(wvalid), .o_wready(wready),
      .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
      .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
      .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
      .i_clock_status(clock_status), .i_sfp_mod_abs(mod_abs),
      .i_sfp_tx_fault(tx_fault), .i_sfp_rx_los(rx_los), .i_phy_status(phy_status),
      .o_leds(leds), .o_sw_rst(sw_rst), .o_clock_control(clock_control),
      .o_sfp_rs_drive_low(rs_drive_low)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // Run limit scales with the number of data lines
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("Error: timeout after %0d cycles, a handshake never finished", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // Random ready delays
   // ----------------------------------------------------------
   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   // Two bits, one LFSR step each
   task automatic draw_delay(output int cycles);
      logic b0;
      logic b1;
      b0         = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      b1         = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      cycles     = {b1, b0};
   endtask

   // ----------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------
   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_status(input string name, input sfp_status_t exp,
                               input sfp_status_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s resp: expected %b, actual %b", name, exp, act);
      end
   endtask

   // ----------------------------------------------------------
   // AXI4-Lite host tasks
   // ----------------------------------------------------------
   task automatic axi_write(input string name, input logic [`BUS_CTRL_AXI_AW-1:0] addr,
                            input reg_data_t data);
      int delay;
      @(posedge clk);
      #2;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      // Ready sampled mid-cycle, handshake at the next edge
      // AW and W both have to be taken
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      @(posedge clk);
      #2;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      draw_delay(delay);
      repeat (delay) begin
         @(posedge clk);
         #2;
      end
      bready = 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      check_resp(name, 2'b00, bresp);
      @(posedge clk);
      #2;
      bready = 1'b0;
   endtask

   task automatic axi_read(input string name, input logic [`BUS_CTRL_AXI_AW-1:0] addr,
                           output reg_data_t data);
      int delay;
      @(posedge clk);
      #2;
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      #2;
      arvalid = 1'b0;
      draw_delay(delay);
      repeat (delay) begin
         @(posedge clk);
         #2;
      end
      rready = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      data = rdata;
      check_resp(name, 2'b00, rresp);
      @(posedge clk);
      #2;
      rready = 1'b0;
   endtask

   // ----------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------
   initial begin
      int          fd;
      int          n_fields;
      int          port;
      string       line;
      string       op;
      string       name;
      logic [31:0] addr;
      logic [31:0] value;
      logic [31:0] expected;
      reg_index_t  idx;
      reg_data_t   data;
      reg_data_t   first;
      clk          = 1'b0;
      arst_n       = 1'b0;
      awaddr       = '0;
      awvalid      = 1'b0;
      wdata        = '0;
      wvalid       = 1'b0;
      bready       = 1'b0;
      araddr       = '0;
      arvalid      = 1'b0;
      rready       = 1'b0;
      clock_status = 8'h5a;
      mod_abs      = '0;
      tx_fault     = '0;
      rx_los       = '0;
      phy_status   = '0;
      n_checks     = 0;
      n_errors     = 0;
      cycle_count  = 0;
      cycle_limit  = 0;
      lfsr_state   = 32'h679d_8d9d;

      fd = $fopen("test/bus_ctrl_testdata.txt", "r");
      if (fd == 0) begin
         n_errors++;
         $display("Error: the test data file could not be opened");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n_fields = $sscanf(line, "%s %s %h %h %h", op, name, addr, value, expected);
            // Column header lines fall out here
            if (n_fields == 5 && op != "#") begin
               op_q.push_back(op);
               name_q.push_back(name);
               addr_q.push_back(addr);
               value_q.push_back(value);
               exp_q.push_back(expected);
            end
         end
         $fclose(fd);
      end
      cycle_limit = RST_CYCLES + CYCLES_PER_LINE * (op_q.size() + 1);

      repeat (RST_CYCLES) @(posedge clk);
      #2;
      arst_n = 1'b1;

      for (int i = 0; i < op_q.size(); i++) begin
         name     = name_q[i];
         addr     = addr_q[i];
         value    = value_q[i];
         expected = exp_q[i];
         idx      = addr[`BUS_CTRL_AXI_AW-1:2];
         case (op_q[i])
            "W": axi_write(name, addr[`BUS_CTRL_AXI_AW-1:0], value);
            "R": begin
               axi_read(name, addr[`BUS_CTRL_AXI_AW-1:0], data);
               // Port words get the status compare
               if (idx >= RB_SFPP_STATUS0 && idx < RB_SFPP_STATUS0 + `BUS_CTRL_NUM_SFP) begin
                  check_status(name, sfp_status_t'(expected), sfp_status_t'(data));
               end else begin
                  check_data(name, expected, data);
               end
            end
            "P": begin
               // Value packs {phy, mod_abs, tx_fault, rx_los}
               @(posedge clk);
               #2;
               port             = addr;
               phy_status[port] = value[18:3];
               mod_abs[port]    = value[2];
               tx_fault[port]   = value[1];
               rx_los[port]     = value[0];
               repeat (4) @(posedge clk);
            end
            "O": begin
               @(negedge clk);
               check_byte({name, "_leds"}, expected[31:24], leds);
               check_byte({name, "_sw_rst"}, expected[23:16], {4'h0, sw_rst});
               check_byte({name, "_clk_ctrl"}, expected[15:8], clock_control);
               check_byte({name, "_rs"}, expected[7:0], {4'h0, rs_drive_low});
            end
            "C": begin
               axi_read(name, addr[`BUS_CTRL_AXI_AW-1:0], first);
               axi_read(name, addr[`BUS_CTRL_AXI_AW-1:0], data);
               n_checks++;
               if (!(data > first)) begin
                  n_errors++;
                  $display("Fail %s: expected a value above %h, actual %h", name, first, data);
               end
            end
            default: begin
               n_errors++;
               $display("Error: unknown operation %s on line %0d", op_q[i], i);
            end
         endcase
      end

      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- test/bus_ctrl_asserts.sv
// ----------------------------------------------------------
// AXI4-Lite protocol checks, bound to the settings slave
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module bus_ctrl_asserts (
   input logic                        clk,
   input logic                        i_arst_n,
   input logic                        i_awvalid,
   input logic                        i_wvalid,
   input logic                        i_awready,
   input logic                        i_bvalid,
   input logic                        i_bready,
   input logic                        i_rvalid,
   input logic                        i_rready,
   input logic [`BUS_CTRL_DATA_W-1:0] i_rdata,
   input logic                        i_set_stb
);

   // Responses hold until the host takes them
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_bvalid && !i_bready |=> i_bvalid)
      else $error("bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
      else $error("rvalid or rdata changed before rready");

   // One strobe per accepted write
   a_set_stb_width: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_set_stb |=> !i_set_stb)
      else $error("settings strobe wider than one cycle");

   // Write taken only with both valids
   // Strobe and response follow one cycle later
   a_awready_valids: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_awready |-> (i_awvalid && i_wvalid) ##1 (i_set_stb && i_bvalid))
      else $error("awready without both valids, or no strobe and response after it");

endmodule

bind axil_settings_slave bus_ctrl_asserts i_bus_ctrl_asserts (
   .clk(clk), .i_arst_n(i_arst_n),
   .i_awvalid(i_awvalid), .i_wvalid(i_wvalid), .i_awready(o_awready),
   .i_bvalid(o_bvalid), .i_bready(i_bready),
   .i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata),
   .i_set_stb(o_set_stb)
);

//--- logic/bus_ctrl_top.sv
// ----------------------------------------------------------
// Control and status block of the two-port SFP+ board
// Host access over AXI4-Lite, instances and wiring only
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module bus_ctrl_top (
   input  logic                                             clk,
   input  logic                                             i_arst_n,
   // AXI4-Lite write
   input  logic [`BUS_CTRL_AXI_AW-1:0]                      i_awaddr,
   input  logic                                             i_awvalid,
   output logic                                             o_awready,
   input  logic [`BUS_CTRL_DATA_W-1:0]                      i_wdata,
   input  logic                                             i_wvalid,
   output logic                                             o_wready,
   output logic [1:0]                                       o_bresp,
   output logic                                             o_bvalid,
   input  logic                                             i_bready,
   // AXI4-Lite read
   input  logic [`BUS_CTRL_AXI_AW-1:0]                      i_araddr,
   input  logic                                             i_arvalid,
   output logic                                             o_arready,
   output logic [`BUS_CTRL_DATA_W-1:0]                      o_rdata,
   output logic [1:0]                                       o_rresp,
   output logic                                             o_rvalid,
   input  logic                                             i_rready,
   // Board status and SFP+ pins
   input  logic [7:0]                                       i_clock_status,
   input  logic [`BUS_CTRL_NUM_SFP-1:0]                     i_sfp_mod_abs,
   input  logic [`BUS_CTRL_NUM_SFP-1:0]                     i_sfp_tx_fault,
   input  logic [`BUS_CTRL_NUM_SFP-1:0]                     i_sfp_rx_los,
   input  logic [`BUS_CTRL_NUM_SFP-1:0][`BUS_CTRL_PHY_W-1:0] i_phy_status,
   // Settings outputs
   output logic [7:0]                                       o_leds,
   output logic [3:0]                                       o_sw_rst,
   output logic [7:0]                                       o_clock_control,
   output logic [`BUS_CTRL_NUM_SFP-1:0][1:0]                o_sfp_rs_drive_low
);
   import bus_ctrl_pkg::*;

   // Settings bus
   logic       set_stb;
   reg_index_t set_index;
   reg_data_t  set_data;
   // Readback bus
   reg_index_t                           rb_index;
   logic                                 rb_rd_stb;
   reg_data_t                            rb_data;
   sfp_status_t [`BUS_CTRL_NUM_SFP-1:0]  sfp_status;
   logic [`BUS_CTRL_NUM_SFP-1:0]         status_clr;

   axil_settings_slave i_axil_settings_slave (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
      .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
      .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
      .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
      .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
      .o_set_stb(set_stb), .o_set_index(set_index), .o_set_data(set_data),
      .o_rb_index(rb_index), .o_rb_rd_stb(rb_rd_stb), .i_rb_data(rb_data)
   );

   ctrl_setting_regs i_ctrl_setting_regs (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(set_stb), .i_set_index(set_index), .i_set_data(set_data),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control)
   );

   // One monitor per cage
   for (genvar p = 0; p < `BUS_CTRL_NUM_SFP; p++) begin : g_sfp_port
      sfp_port_monitor #(.PORT_IDX(p)) i_sfp_port_monitor (
         .clk(clk), .i_arst_n(i_arst_n),
         .i_set_stb(set_stb), .i_set_index(set_index), .i_set_data(set_data),
         .i_mod_abs(i_sfp_mod_abs[p]), .i_tx_fault(i_sfp_tx_fault[p]),
         .i_rx_los(i_sfp_rx_los[p]), .i_phy_status(i_phy_status[p]),
         .i_status_clr(status_clr[p]), .o_status(sfp_status[p]),
         .o_rs_drive_low(o_sfp_rs_drive_low[p])
      );
   end

   readback_mux i_readback_mux (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_rb_index(rb_index), .i_rb_rd_stb(rb_rd_stb),
      .i_clock_status(i_clock_status), .i_sfp_status(sfp_status),
      .o_rb_data(rb_data), .o_status_clr(status_clr)
   );

endmodule

//--- logic/readback_mux.sv
// ----------------------------------------------------------
// Readback word select, free-running counter and the
// per-port clear-on-read pulses
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module readback_mux (
   input  logic                                              clk,
   input  logic                                              i_arst_n,
   input  bus_ctrl_pkg::reg_index_t                          i_rb_index,
   input  logic                                              i_rb_rd_stb,
   input  logic [7:0]                                        i_clock_status,
   input  bus_ctrl_pkg::sfp_status_t [`BUS_CTRL_NUM_SFP-1:0] i_sfp_status,
   output bus_ctrl_pkg::reg_data_t                           o_rb_data,
   output logic [`BUS_CTRL_NUM_SFP-1:0]                      o_status_clr
);
   import bus_ctrl_pkg::*;

   reg_data_t                   counter;
   logic [`BUS_CTRL_NUM_SFP-1:0] port_hit;

   // Free-running, wraps
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // Port status indices decoded once, shared by data and clear
   for (genvar p = 0; p < `BUS_CTRL_NUM_SFP; p++) begin : g_port_hit
      assign port_hit[p] = (i_rb_index == reg_index_t'(RB_SFPP_STATUS0 + p));
   end

   assign o_status_clr = port_hit & {`BUS_CTRL_NUM_SFP{i_rb_rd_stb}};

   always_comb begin
      case (i_rb_index)
         RB_COUNTER:    o_rb_data = counter;
         RB_CLK_STATUS: o_rb_data = reg_data_t'(i_clock_status);
         RB_ETH_TYPE0:  o_rb_data = `BUS_CTRL_ETH_TYPE0;
         RB_ETH_TYPE1:  o_rb_data = `BUS_CTRL_ETH_TYPE1;
         RB_COMPAT_NUM: o_rb_data = `BUS_CTRL_COMPAT;
         // Unmapped reads as 0
         default:       o_rb_data = '0;
      endcase
      // Port words sit outside the fixed map
      for (int p = 0; p < `BUS_CTRL_NUM_SFP; p++) begin
         if (port_hit[p]) begin
            o_rb_data = i_sfp_status[p];
         end
      end
   end

endmodule

//--- logic/sfp_port_monitor.sv
// ----------------------------------------------------------
// One SFP+ port: pin and PHY synchronisers, change latches
// and the RS0/RS1 rate-select register
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module sfp_port_monitor #(
   parameter int PORT_IDX = 0
) (
   input  logic                        clk,
   input  logic                        i_arst_n,
   input  logic                        i_set_stb,
   input  bus_ctrl_pkg::reg_index_t    i_set_index,
   input  bus_ctrl_pkg::reg_data_t     i_set_data,
   // Module pins, asynchronous
   input  logic                        i_mod_abs,
   input  logic                        i_tx_fault,
   input  logic                        i_rx_los,
   input  logic [`BUS_CTRL_PHY_W-1:0]  i_phy_status,
   // Host read of this port's status word
   input  logic                        i_status_clr,
   output bus_ctrl_pkg::sfp_status_t   o_status,
   output logic [1:0]                  o_rs_drive_low
);
   import bus_ctrl_pkg::*;

   // PHY bits plus the three pins
   localparam int SYNC_W = `BUS_CTRL_PHY_W + 3;
   localparam reg_index_t CTRL_IDX = reg_index_t'(SR_SFPP_CTRL0 + PORT_IDX);

   logic [SYNC_W-1:0] sync_meta;
   logic [SYNC_W-1:0] sync_out;
   logic [2:0]        pins_now;
   logic [2:0]        pins_dly;
   logic [2:0]        pins_chgd;

   // Two-flop synchronisers
   // Every bit treated as unrelated to the others
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_meta <= '0;
         sync_out  <= '0;
      end else begin
         sync_meta <= {i_phy_status, i_mod_abs, i_tx_fault, i_rx_los};
         sync_out  <= sync_meta;
      end
   end

   // ModAbs, TxFault, RxLOS
   assign pins_now = sync_out[2:0];

   // Sticky change flags, the host read wins over a new edge
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_dly  <= 3'b000;
         pins_chgd <= 3'b000;
      end else begin
         pins_dly <= pins_now;
         if (i_status_clr) begin
            pins_chgd <= 3'b000;
         end else begin
            pins_chgd <= pins_chgd | (pins_now ^ pins_dly);
         end
      end
   end

   assign o_status = {sync_out[SYNC_W-1:3], 10'b0, pins_chgd, pins_now};

   // RS pins are open drain on the board
   // Bit set means pull that pin low
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rs_drive_low <= 2'b00;
      end else if (i_set_stb && (i_set_index == CTRL_IDX)) begin
         o_rs_drive_low <= i_set_data[1:0];
      end
   end

endmodule

//--- logic/ctrl_setting_regs.sv
// ----------------------------------------------------------
// LED, soft-reset and clock-control setting registers
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module ctrl_setting_regs (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic                     i_set_stb,
   input  bus_ctrl_pkg::reg_index_t i_set_index,
   input  bus_ctrl_pkg::reg_data_t  i_set_data,
   output logic [7:0]               o_leds,
   // Soft reset bits
   // [0] PHY, [1] radio domain, [2] radio PLL, [3] ADC IDELAYCTRL
   output logic [3:0]               o_sw_rst,
   output logic [7:0]               o_clock_control
);
   import bus_ctrl_pkg::*;

   // Each register picks its own index off the bus
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_leds          <= 8'h00;
         o_sw_rst        <= 4'h0;
         o_clock_control <= `BUS_CTRL_CLK_CTRL_RST;
      end else if (i_set_stb) begin
         if (i_set_index == SR_LEDS) begin
            o_leds <= i_set_data[7:0];
         end
         if (i_set_index == SR_SW_RST) begin
            o_sw_rst <= i_set_data[3:0];
         end
         // Bit 6 selects the GPSDO
         if (i_set_index == SR_CLOCK_CTRL) begin
            o_clock_control <= i_set_data[7:0];
         end
      end
   end

endmodule

//--- logic/axil_settings_slave.sv
// ----------------------------------------------------------
// AXI4-Lite slave for the host
// Writes become settings strobes, reads become readback cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_cfg.svh"

module axil_settings_slave (
   input  logic                        clk,
   input  logic                        i_arst_n,
   // Write address, data and response
   input  logic [`BUS_CTRL_AXI_AW-1:0] i_awaddr,
   input  logic                        i_awvalid,
   output logic                        o_awready,
   input  logic [`BUS_CTRL_DATA_W-1:0] i_wdata,
   input  logic                        i_wvalid,
   output logic                        o_wready,
   output logic [1:0]                  o_bresp,
   output logic                        o_bvalid,
   input  logic                        i_bready,
   // Read address and data
   input  logic [`BUS_CTRL_AXI_AW-1:0] i_araddr,
   input  logic                        i_arvalid,
   output logic                        o_arready,
   output logic [`BUS_CTRL_DATA_W-1:0] o_rdata,
   output logic [1:0]                  o_rresp,
   output logic                        o_rvalid,
   input  logic                        i_rready,
   // Settings and readback buses
   output logic                        o_set_stb,
   output bus_ctrl_pkg::reg_index_t    o_set_index,
   output bus_ctrl_pkg::reg_data_t     o_set_data,
   output bus_ctrl_pkg::reg_index_t    o_rb_index,
   output logic                        o_rb_rd_stb,
   input  bus_ctrl_pkg::reg_data_t     i_rb_data
);
   import bus_ctrl_pkg::*;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   axil_wr_state_e wr_state;
   axil_rd_state_e rd_state;
   logic           wr_accept;
   logic           rd_accept;

   // ----------------------------------------------------------
   // Write side
   // ----------------------------------------------------------
   // AW and W taken together, never one alone
   assign wr_accept = (wr_state == WR_IDLE) && i_awvalid && i_wvalid;
   assign o_awready = wr_accept;
   assign o_wready  = wr_accept;
   assign o_bvalid  = (wr_state == WR_RESP);
   // Unclaimed indices still answer OKAY
   assign o_bresp   = RESP_OKAY;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_state  <= WR_IDLE;
         o_set_stb <= 1'b0;
      end else begin
         // Strobe lands with bvalid, one cycle after acceptance
         o_set_stb <= wr_accept;
         if (wr_accept) begin
            wr_state <= WR_RESP;
         end else if (o_bvalid && i_bready) begin
            wr_state <= WR_IDLE;
         end
      end
   end

   // Index and data stay put until the next accepted write
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         o_set_index <= i_awaddr[`BUS_CTRL_AXI_AW-1:2];
         o_set_data  <= i_wdata;
      end
   end

   // ----------------------------------------------------------
   // Read side
   // ----------------------------------------------------------
   assign o_arready   = (rd_state == RD_IDLE);
   assign rd_accept   = o_arready && i_arvalid;
   // Clear pulse shares the edge that samples the word
   assign o_rb_rd_stb = (rd_state == RD_FETCH);
   assign o_rvalid    = (rd_state == RD_DATA);
   assign o_rresp     = RESP_OKAY;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE:  if (rd_accept) rd_state <= RD_FETCH;
            RD_FETCH: rd_state <= RD_DATA;
            RD_DATA:  if (i_rready) rd_state <= RD_IDLE;
            default:  rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept) begin
         o_rb_index <= i_araddr[`BUS_CTRL_AXI_AW-1:2];
      end
      // Held through RD_DATA until rready
      if (o_rb_rd_stb) begin
         o_rdata <= i_rb_data;
      end
   end

endmodule

//--- logic/bus_ctrl_pkg.sv
// ----------------------------------------------------------
// Register maps, bus word types and AXI4-Lite FSM states
// ----------------------------------------------------------
`include "bus_ctrl_cfg.svh"

package bus_ctrl_pkg;

   // Register index and data word
   typedef logic [`BUS_CTRL_REG_AW-1:0] reg_index_t;
   typedef logic [`BUS_CTRL_DATA_W-1:0] reg_data_t;

   // Settings indices, port n at SR_SFPP_CTRL0 + n
   typedef enum logic [`BUS_CTRL_REG_AW-1:0] {
      SR_LEDS       = 'd0,
      SR_SW_RST     = 'd1,
      SR_CLOCK_CTRL = 'd2,
      SR_SFPP_CTRL0 = 'd8
   } sr_index_e;

   // Readback indices, port n at RB_SFPP_STATUS0 + n
   typedef enum logic [`BUS_CTRL_REG_AW-1:0] {
      RB_COUNTER      = 'd0,
      RB_CLK_STATUS   = 'd3,
      RB_ETH_TYPE0    = 'd4,
      RB_ETH_TYPE1    = 'd5,
      RB_COMPAT_NUM   = 'd6,
      RB_SFPP_STATUS0 = 'd8
   } rb_index_e;

   typedef enum logic {WR_IDLE, WR_RESP} axil_wr_state_e;
   typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_DATA} axil_rd_state_e;

   // Port status word as seen by the host
   typedef struct packed {
      logic [`BUS_CTRL_PHY_W-1:0] phy_status;
      logic [9:0]                 rsvd;
      logic                       mod_abs_chgd;
      logic                       tx_fault_chgd;
      logic                       rx_los_chgd;
      logic                       mod_abs;
      logic                       tx_fault;
      logic                       rx_los;
   } sfp_status_t;

endpackage

//--- logic/bus_ctrl_cfg.svh
// ----------------------------------------------------------
// Build-time constants for the board control block
// Included by the package and by every module that sizes ports
// ----------------------------------------------------------
`ifndef BUS_CTRL_CFG_SVH
`define BUS_CTRL_CFG_SVH

// Port count and bus widths
`define BUS_CTRL_NUM_SFP      2
`define BUS_CTRL_DATA_W       32
`define BUS_CTRL_REG_AW       8
// Byte address, word index sits in bits 9:2
`define BUS_CTRL_AXI_AW       10
`define BUS_CTRL_PHY_W        16

// Compatibility number, major 0x000F, minor 0x0000
`define BUS_CTRL_COMPAT       32'h000F_0000

// Ethernet type per port, 1 = 10G, 0 = 1G
`define BUS_CTRL_ETH_TYPE0    32'd1
`define BUS_CTRL_ETH_TYPE1    32'd0

// Bit 6 set keeps the GPSDO on out of reset
`define BUS_CTRL_CLK_CTRL_RST 8'h40

`endif
